// ==== src.f ====
logic/mem_subsys_pkg.sv
logic/biu_ahb3lite.sv
logic/fetch_unit.sv
logic/dmem_ctrl.sv
logic/mem_subsys_top.sv
bench/tb_clkgen.sv
bench/mem_subsys_sva.sv
bench/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, check the log for a pass"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wall -Wno-fatal -f src.f \
		--top-module tb_mem_subsys -Mdir obj_dir -o Vtb_mem_subsys
	./obj_dir/Vtb_mem_subsys | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_mem_subsys.sv ====
// Testbench top for the memory subsystem
// Instruction and data AHB-Lite slave models with random wait states
// Fetch, flush, load/store, misaligned and bus error sequences

`timescale 1ns/1ps

module tb_mem_subsys
  import mem_subsys_pkg::*;
();

  logic clk, arst_n;
  ahb_m2s_t ins_m2s, dat_m2s;
  ahb_s2m_t ins_s2m, dat_s2m;
  logic flush_i, stall_i, mem_req_i, mem_we_i;
  addr_t nxt_pc_i, mem_adr_i, parcel_pc_o;
  biu_size_t mem_size_i;
  data_t mem_d_i, parcel_o, mem_q_o;
  logic parcel_valid_o, parcel_misaligned_o, parcel_err_o;
  logic mem_ack_o, mem_err_o, mem_misaligned_o;

  int errors = 0;
  int timeouts = 0;
  logic [7:0] ref_mem [0:1023];   // Expected data bytes by low address bits

  tb_clkgen u_clkgen (.clk_o(clk), .arst_n_o(arst_n));

  mem_subsys_top u_mem_subsys_top (
    .clk_i(clk), .arst_n_i(arst_n),
    .ins_ahb_o(ins_m2s), .ins_ahb_i(ins_s2m), .dat_ahb_o(dat_m2s), .dat_ahb_i(dat_s2m),
    .*
  );

  ////////////////////////////////////////////////////////////////////////////
  // Slave models
  ////////////////////////////////////////////////////////////////////////////
  logic  i_ph, i_err, d_ph, d_err, d_we;
  addr_t i_adr, d_adr;
  biu_size_t d_size;
  logic [3:0] d_mask;
  int    i_wait, d_wait, i_draw, d_draw;
  data_t ram [0:255];

  function automatic logic [3:0] lane_mask(biu_size_t size, addr_t adr);
    case (size)
      SIZE_BYTE: return 4'b0001 << adr[1:0];
      SIZE_HALF: return adr[1] ? 4'b1100 : 4'b0011;
      default:   return 4'b1111;
    endcase
  endfunction

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ins_s2m <= '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
      i_ph    <= 1'b0;
    end else if (i_ph && !ins_s2m.hready) begin
      if (i_err || i_wait <= 1) begin
        ins_s2m.hready <= 1'b1;
        ins_s2m.hrdata <= {i_adr[31:2], 2'b00} ^ 32'h5A5A_0000;
      end
      i_wait <= i_wait - 1;
    end else begin
      i_ph           <= 1'b0;
      ins_s2m.hresp  <= 1'b0;
      if (ins_m2s.htrans == HTRANS_NONSEQ) begin
        check_val("ins_ahb_o.hprot", 4'b0010, ins_m2s.hprot);   // Privileged opcode fetch
        check_val("ins_ahb_o.hsize", 3'd2, ins_m2s.hsize);
        i_draw = $urandom % 3;
        i_ph   <= 1'b1;
        i_adr  <= ins_m2s.haddr;
        i_err  <= ins_m2s.haddr >= 32'hF000_0000;
        i_wait <= i_draw;
        if (ins_m2s.haddr >= 32'hF000_0000) begin   // Two-cycle ERROR
          ins_s2m.hready <= 1'b0;
          ins_s2m.hresp  <= 1'b1;
        end else begin
          ins_s2m.hready <= i_draw == 0;
          ins_s2m.hrdata <= {ins_m2s.haddr[31:2], 2'b00} ^ 32'h5A5A_0000;
        end
      end
    end
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dat_s2m <= '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
      d_ph    <= 1'b0;
    end else if (d_ph && !dat_s2m.hready) begin
      if (d_err || d_wait <= 1) begin
        dat_s2m.hready <= 1'b1;
        dat_s2m.hrdata <= ram[d_adr[9:2]];
      end
      d_wait <= d_wait - 1;
    end else begin
      // Write data arrives in the data phase that ends here
      if (d_ph && d_we && !d_err) begin
        d_mask = lane_mask(d_size, d_adr);
        for (int b = 0; b < 4; b++) begin
          if (d_mask[b]) ram[d_adr[9:2]][8*b +: 8] = dat_m2s.hwdata[8*b +: 8];
        end
      end
      d_ph          <= 1'b0;
      dat_s2m.hresp <= 1'b0;
      if (dat_m2s.htrans == HTRANS_NONSEQ) begin
        check_val("dat_ahb_o.hprot", 4'b0011, dat_m2s.hprot);   // Privileged data access
        d_draw = $urandom % 3;
        d_ph   <= 1'b1;
        d_adr  <= dat_m2s.haddr;
        d_we   <= dat_m2s.hwrite;
        d_size <= dat_m2s.hsize;
        d_err  <= dat_m2s.haddr >= 32'hF000_0000;
        d_wait <= d_draw;
        if (dat_m2s.haddr >= 32'hF000_0000) begin
          dat_s2m.hready <= 1'b0;
          dat_s2m.hresp  <= 1'b1;
        end else begin
          dat_s2m.hready <= d_draw == 0;
          dat_s2m.hrdata <= ram[dat_m2s.haddr[9:2]];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking and run control
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic finish_run;
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) $display("TEST RESULT: PASS");
    else $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    timeouts++;
    $display("Timeout at %0t: %s", $time, what);
    finish_run();
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  // Takes the next parcel with optional random back-pressure
  task automatic get_parcel(input bit rnd, output data_t d, output addr_t pc,
                            output logic mis, output logic err);
    int  n;
    bit  got;
    n   = 0;
    got = 0;
    while (!got) begin
      stall_i = rnd ? ($urandom % 3 == 0) : 1'b0;
      if (parcel_valid_o && !stall_i) begin
        d   = parcel_o;
        pc  = parcel_pc_o;
        mis = parcel_misaligned_o;
        err = parcel_err_o;
        got = 1;
      end
      next_cycle();
      if (++n > 200) timeout_abort("no parcel from the fetch unit");
    end
    stall_i = 1'b1;
  endtask

  task automatic check_parcel(input bit rnd, input addr_t exp_pc, input logic exp_mis,
                              input logic exp_err);
    data_t d;
    addr_t pc;
    logic  mis, err;
    get_parcel(rnd, d, pc, mis, err);
    check_val("parcel_pc_o", exp_pc, pc);
    check_val("parcel_misaligned_o", exp_mis, mis);
    check_val("parcel_err_o", exp_err, err);
    if (!exp_mis && !exp_err) check_val("parcel_o", exp_pc ^ 32'h5A5A_0000, d);
  endtask

  task automatic flush_to(input addr_t pc);
    flush_i  = 1'b1;
    nxt_pc_i = pc;
    next_cycle();
    flush_i  = 1'b0;
  endtask

  task automatic mem_op(input logic we, input addr_t adr, input biu_size_t size,
                        input data_t d, input bit idle_port, output data_t q,
                        output logic err, output logic mis);
    int n;
    bit done;
    n = 0;
    done = 0;
    mem_req_i  = 1'b1;
    mem_we_i   = we;
    mem_adr_i  = adr;
    mem_size_i = size;
    mem_d_i    = d;
    while (!done) begin
      if (idle_port) check_val("dat_ahb_o.htrans", HTRANS_IDLE, dat_m2s.htrans);
      if (mem_ack_o || mem_err_o) begin
        q    = mem_q_o;
        err  = mem_err_o;
        mis  = mem_misaligned_o;
        done = 1;
      end
      next_cycle();
      if (++n > 100) timeout_abort("no response from the data controller");
    end
    mem_req_i = 1'b0;
  endtask

  task automatic store(input addr_t adr, input biu_size_t size, input data_t d);
    data_t q;
    logic  err, mis;
    mem_op(1'b1, adr, size, d, 1'b0, q, err, mis);
    check_val("mem_err_o", 1'b0, err);
    for (int i = 0; i < (1 << size); i++) ref_mem[adr[9:0] + i] = d[8*i +: 8];
  endtask

  task automatic load_check(input addr_t adr, input biu_size_t size);
    data_t q, exp;
    logic  err, mis;
    exp = '0;
    for (int i = 0; i < (1 << size); i++) exp[8*i +: 8] = ref_mem[adr[9:0] + i];
    mem_op(1'b0, adr, size, '0, 1'b0, q, err, mis);
    check_val("mem_err_o", 1'b0, err);
    check_val("mem_q_o", exp, q);
  endtask

  task automatic expect_err(input logic we, input addr_t adr, input biu_size_t size,
                            input logic exp_mis);
    data_t q;
    logic  err, mis;
    mem_op(we, adr, size, 32'hDEAD_BEEF, exp_mis, q, err, mis);
    check_val("mem_err_o", 1'b1, err);
    check_val("mem_misaligned_o", exp_mis, mis);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int rst_cycles;
    void'($urandom(32));
    flush_i = 1'b0;
    stall_i = 1'b0;
    nxt_pc_i = '0;
    mem_req_i = 1'b0;
    mem_we_i = 1'b0;
    mem_adr_i = '0;
    mem_size_i = SIZE_WORD;
    mem_d_i = '0;
    rst_cycles = 0;
    while (arst_n !== 1'b1) begin
      @(posedge clk);
      if (++rst_cycles > 20) timeout_abort("reset was never released");
    end
    next_cycle();

    // Sequential fetch under random stalls
    for (int i = 0; i < 24; i++) check_parcel(1'b1, PC_INIT + 4 * i, 1'b0, 1'b0);

    // Flush with requests on the bus
    stall_i = 1'b0;
    next_cycle();
    next_cycle();
    flush_to(32'h0000_1000);
    for (int i = 0; i < 6; i++) check_parcel(1'b1, 32'h1000 + 4 * i, 1'b0, 1'b0);

    // Misaligned flush target leaves the port quiet
    flush_to(32'h0000_2002);
    check_parcel(1'b0, 32'h0000_2002, 1'b1, 1'b0);
    repeat (4) next_cycle();
    for (int i = 0; i < 5; i++) begin
      check_val("ins_ahb_o.htrans", HTRANS_IDLE, ins_m2s.htrans);
      check_val("parcel_valid_o", 1'b0, parcel_valid_o);
      next_cycle();
    end

    // Instruction bus error and recovery
    flush_to(32'hF000_0000);
    check_parcel(1'b0, 32'hF000_0000, 1'b0, 1'b1);
    flush_to(32'h0000_0300);
    for (int i = 0; i < 4; i++) check_parcel(1'b1, 32'h300 + 4 * i, 1'b0, 1'b0);
    stall_i = 1'b1;

    // Stores of every size and offset followed by loads of every size
    for (int a = 'h40; a < 'h50; a += 4) store(a, SIZE_WORD, $urandom);
    for (int a = 'h50; a < 'h58; a += 2) store(a, SIZE_HALF, $urandom);
    for (int a = 'h58; a < 'h60; a++)    store(a, SIZE_BYTE, $urandom);
    for (int a = 'h40; a < 'h60; a++) begin
      load_check(a, SIZE_BYTE);
      if (a % 2 == 0) load_check(a, SIZE_HALF);
      if (a % 4 == 0) load_check(a, SIZE_WORD);
    end

    // Misaligned data accesses
    expect_err(1'b0, 32'h41, SIZE_HALF, 1'b1);
    expect_err(1'b1, 32'h43, SIZE_HALF, 1'b1);
    expect_err(1'b0, 32'h42, SIZE_WORD, 1'b1);
    expect_err(1'b1, 32'h41, SIZE_WORD, 1'b1);

    // Data bus errors followed by a normal access
    expect_err(1'b0, 32'hF000_0010, SIZE_WORD, 1'b0);
    expect_err(1'b1, 32'hF000_0005, SIZE_BYTE, 1'b0);
    store(32'h64, SIZE_WORD, 32'h1357_9BDF);
    load_check(32'h64, SIZE_WORD);
    load_check(32'h66, SIZE_HALF);

    repeat (3) next_cycle();
    finish_run();
  end

endmodule

// ==== bench/mem_subsys_sva.sv ====
// Concurrent checks on the AHB-Lite ports and core-side handshakes
// Bound into the memory subsystem top level

`timescale 1ns/1ps

module mem_subsys_sva
  import mem_subsys_pkg::*;
(
  input logic     clk_i,
  input logic     arst_n_i,
  input ahb_m2s_t ins_ahb_o,
  input ahb_s2m_t ins_ahb_i,
  input ahb_m2s_t dat_ahb_o,
  input ahb_s2m_t dat_ahb_i,
  input logic     parcel_valid_o,
  input logic     parcel_misaligned_o,
  input addr_t    parcel_pc_o,
  input logic     mem_ack_o,
  input logic     mem_err_o,
  input logic     ins_err,
  input logic     dat_ack,
  input logic     dat_err
);

  ////////////////////////////////////////////////////////////////////////////
  // AHB-Lite side
  ////////////////////////////////////////////////////////////////////////////
  a_idle_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> ins_ahb_o.htrans == HTRANS_IDLE && dat_ahb_o.htrans == HTRANS_IDLE)
    else $error("HTRANS not IDLE during reset");

  a_ins_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ins_ahb_o.htrans == HTRANS_NONSEQ && !ins_ahb_i.hready) |=>
      $stable(ins_ahb_o.haddr) && $stable(ins_ahb_o.htrans) && $stable(ins_ahb_o.hwrite)
      && $stable(ins_ahb_o.hsize))
    else $error("Instruction port address phase changed under wait state");

  a_dat_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (dat_ahb_o.htrans == HTRANS_NONSEQ && !dat_ahb_i.hready) |=>
      $stable(dat_ahb_o.haddr) && $stable(dat_ahb_o.htrans) && $stable(dat_ahb_o.hwrite)
      && $stable(dat_ahb_o.hsize))
    else $error("Data port address phase changed under wait state");

  ////////////////////////////////////////////////////////////////////////////
  // Core side
  ////////////////////////////////////////////////////////////////////////////
  // Pipelined fetches may acknowledge on consecutive cycles
  a_pulses: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mem_ack_o || mem_err_o || ins_err || dat_ack || dat_err) |=>
      !($past(mem_ack_o) && mem_ack_o) && !($past(mem_err_o) && mem_err_o)
      && !($past(ins_err) && ins_err)
      && !($past(dat_ack) && dat_ack) && !($past(dat_err) && dat_err))
    else $error("Acknowledge or error held longer than one cycle");

  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (parcel_valid_o && !parcel_misaligned_o) |-> parcel_pc_o[1:0] == 2'b00)
    else $error("Unaligned parcel pc without misaligned flag");

endmodule

bind mem_subsys_top mem_subsys_sva u_sva (.*);

// ==== bench/tb_clkgen.sv ====
// Testbench clock and reset generator
// 8 ns clock, active-low reset held for 5 rising edges

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 arst_n_o = 1'b1;   // Released just after an edge
  end

endmodule

// ==== logic/mem_subsys_top.sv ====
// Memory subsystem top level
// Fetch unit and data controller, each on its own AHB-Lite master

`timescale 1ns/1ps

module mem_subsys_top
  import mem_subsys_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  // AHB-Lite ports, HSEL tied high at the slave
  output ahb_m2s_t  ins_ahb_o,
  input  ahb_s2m_t  ins_ahb_i,
  output ahb_m2s_t  dat_ahb_o,
  input  ahb_s2m_t  dat_ahb_i,

  // Fetch
  input  logic      flush_i,
  input  logic      stall_i,
  input  addr_t     nxt_pc_i,
  output data_t     parcel_o,
  output addr_t     parcel_pc_o,
  output logic      parcel_valid_o,
  output logic      parcel_misaligned_o,
  output logic      parcel_err_o,

  // Data
  input  logic      mem_req_i,
  input  logic      mem_we_i,
  input  addr_t     mem_adr_i,
  input  biu_size_t mem_size_i,
  input  data_t     mem_d_i,
  output data_t     mem_q_o,
  output logic      mem_ack_o,
  output logic      mem_err_o,
  output logic      mem_misaligned_o
);

  logic     ins_stb, ins_stb_ack, ins_ack, ins_err;   // Instruction BIU
  biu_req_t ins_req;
  data_t    ins_q;
  logic     dat_stb, dat_stb_ack, dat_ack, dat_err;   // Data BIU
  biu_req_t dat_req;
  data_t    dat_q;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction path
  ////////////////////////////////////////////////////////////////////////////
  fetch_unit u_fetch_unit (
    .biu_stb_o     (ins_stb),
    .biu_req_o     (ins_req),
    .biu_stb_ack_i (ins_stb_ack),
    .biu_ack_i     (ins_ack),
    .biu_err_i     (ins_err),
    .biu_q_i       (ins_q),
    .*
  );

  biu_ahb3lite u_ins_biu (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .biu_stb_i     (ins_stb),
    .biu_req_i     (ins_req),
    .biu_stb_ack_o (ins_stb_ack),
    .biu_ack_o     (ins_ack),
    .biu_err_o     (ins_err),
    .biu_q_o       (ins_q),
    .ahb_i         (ins_ahb_i),
    .ahb_o         (ins_ahb_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////
  dmem_ctrl u_dmem_ctrl (
    .biu_stb_o     (dat_stb),
    .biu_req_o     (dat_req),
    .biu_stb_ack_i (dat_stb_ack),
    .biu_ack_i     (dat_ack),
    .biu_err_i     (dat_err),
    .biu_q_i       (dat_q),
    .*
  );

  biu_ahb3lite u_dat_biu (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .biu_stb_i     (dat_stb),
    .biu_req_i     (dat_req),
    .biu_stb_ack_o (dat_stb_ack),
    .biu_ack_o     (dat_ack),
    .biu_err_o     (dat_err),
    .biu_q_o       (dat_q),
    .ahb_i         (dat_ahb_i),
    .ahb_o         (dat_ahb_o)
  );

endmodule

// ==== logic/dmem_ctrl.sv ====
// Data memory access controller
// Alignment check, store lane replication, load lane extraction
// One outstanding bus access, three-state FSM

`timescale 1ns/1ps

module dmem_ctrl
  import mem_subsys_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      mem_req_i,
  input  logic      mem_we_i,
  input  addr_t     mem_adr_i,
  input  biu_size_t mem_size_i,
  input  data_t     mem_d_i,
  output data_t     mem_q_o,
  output logic      mem_ack_o,
  output logic      mem_err_o,
  output logic      mem_misaligned_o,
  output logic      biu_stb_o,
  output biu_req_t  biu_req_o,
  input  logic      biu_stb_ack_i,
  input  logic      biu_ack_i,
  input  logic      biu_err_i,
  input  data_t     biu_q_i
);

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_t;

  state_t   state;
  logic     misal_r;    // Current access was rejected
  biu_req_t req_r;
  logic     misal;
  data_t    wdat;
  data_t    lane;

  ////////////////////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (mem_size_i)
      SIZE_BYTE: begin
        misal = 1'b0;
        wdat  = {4{mem_d_i[7:0]}};
      end
      SIZE_HALF: begin
        misal = mem_adr_i[0];
        wdat  = {2{mem_d_i[15:0]}};
      end
      default: begin
        misal = |mem_adr_i[1:0];
        wdat  = mem_d_i;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state   <= IDLE;
      misal_r <= 1'b0;
    end else begin
      case (state)
        IDLE: if (mem_req_i) begin
          misal_r <= misal;
          state   <= misal ? WAIT : ISSUE;   // Misaligned skips the bus
        end
        ISSUE: if (biu_stb_ack_i) state <= WAIT;
        WAIT:  if (misal_r || biu_ack_i || biu_err_i) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == IDLE && mem_req_i) begin
      req_r <= '{adr: mem_adr_i, size: mem_size_i, we: mem_we_i, prot: PROT_DATA, d: wdat};
    end
  end

  assign biu_stb_o = state == ISSUE;
  assign biu_req_o = req_r;

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////
  assign lane = biu_q_i >> {req_r.adr[1:0], 3'b000};   // Addressed lane to bit 0

  always_comb begin
    case (req_r.size)
      SIZE_BYTE: mem_q_o = {24'h0, lane[7:0]};
      SIZE_HALF: mem_q_o = {16'h0, lane[15:0]};
      default:   mem_q_o = lane;
    endcase
  end

  assign mem_ack_o        = (state == WAIT) & ~misal_r & biu_ack_i;
  assign mem_err_o        = (state == WAIT) & (misal_r | biu_err_i);
  assign mem_misaligned_o = (state == WAIT) & misal_r;

endmodule

// ==== logic/fetch_unit.sv ====
// Sequential instruction parcel prefetcher
// Fetch pc, in-flight pc tracking and stale-response discard after flush
// Two-entry parcel queue with misaligned and bus error flags

`timescale 1ns/1ps

module fetch_unit
  import mem_subsys_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,
  input  logic     stall_i,
  input  addr_t    nxt_pc_i,
  output data_t    parcel_o,
  output addr_t    parcel_pc_o,
  output logic     parcel_valid_o,
  output logic     parcel_misaligned_o,
  output logic     parcel_err_o,
  output logic     biu_stb_o,
  output biu_req_t biu_req_o,
  input  logic     biu_stb_ack_i,
  input  logic     biu_ack_i,
  input  logic     biu_err_i,
  input  data_t    biu_q_i
);

  typedef struct packed {
    data_t parcel;
    addr_t pc;
    logic  misaligned;
    logic  err;
  } fq_entry_t;

  addr_t      fetch_pc, issue_pc;
  logic       halted;                   // Parked on a misaligned pc
  logic       nxt_mis;
  addr_t      infl_pc [2];              // Pcs of requests on the bus
  logic       infl_wp, infl_rp;
  logic [1:0] infl_cnt, stale_cnt, live_cnt;
  logic       resp, resp_live;
  fq_entry_t  fq [2];
  fq_entry_t  fq_din;
  logic       fq_wp, fq_rp, fq_push, fq_pop;
  logic [1:0] fq_cnt;
  logic [2:0] budget;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////
  assign nxt_mis   = |nxt_pc_i[1:0];
  assign issue_pc  = flush_i ? nxt_pc_i : fetch_pc;   // Flush target goes out at once
  assign live_cnt  = infl_cnt - stale_cnt;
  assign budget    = {1'b0, fq_cnt} + {1'b0, live_cnt};
  assign biu_stb_o = flush_i ? ~nxt_mis : (~halted & (budget < 3'd2));
  assign biu_req_o = '{adr: issue_pc, size: SIZE_WORD, we: 1'b0, prot: PROT_INSTR, d: '0};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_pc <= PC_INIT;
      halted   <= 1'b0;
    end else begin
      if (biu_stb_ack_i)  fetch_pc <= issue_pc + addr_t'(4);
      else if (flush_i)   fetch_pc <= nxt_pc_i;
      if (flush_i)        halted   <= nxt_mis;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // In-flight tracking
  ////////////////////////////////////////////////////////////////////////////
  assign resp      = biu_ack_i | biu_err_i;
  assign resp_live = resp & (stale_cnt == 2'd0) & ~flush_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      infl_wp   <= 1'b0;
      infl_rp   <= 1'b0;
      infl_cnt  <= 2'd0;
      stale_cnt <= 2'd0;
    end else begin
      if (biu_stb_ack_i) infl_wp <= ~infl_wp;
      if (resp)          infl_rp <= ~infl_rp;
      infl_cnt <= infl_cnt + {1'b0, biu_stb_ack_i} - {1'b0, resp};
      // Everything already on the bus is dropped, except a strobe taken now
      if (flush_i)                        stale_cnt <= infl_cnt - {1'b0, resp};
      else if (resp && stale_cnt != 2'd0) stale_cnt <= stale_cnt - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (biu_stb_ack_i) infl_pc[infl_wp] <= issue_pc;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Parcel queue
  ////////////////////////////////////////////////////////////////////////////
  assign fq_push = flush_i ? nxt_mis : resp_live;
  assign fq_pop  = parcel_valid_o & ~stall_i & ~flush_i;
  assign fq_din  = flush_i ? '{parcel: '0, pc: nxt_pc_i, misaligned: 1'b1, err: 1'b0}
                           : '{parcel: biu_q_i, pc: infl_pc[infl_rp], misaligned: 1'b0,
                               err: biu_err_i};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fq_wp  <= 1'b0;
      fq_rp  <= 1'b0;
      fq_cnt <= 2'd0;
    end else if (flush_i) begin
      fq_rp  <= 1'b0;                   // Misaligned marker lands in entry 0
      fq_wp  <= nxt_mis;
      fq_cnt <= {1'b0, nxt_mis};
    end else begin
      if (fq_push) fq_wp <= ~fq_wp;
      if (fq_pop)  fq_rp <= ~fq_rp;
      fq_cnt <= fq_cnt + {1'b0, fq_push} - {1'b0, fq_pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (fq_push) fq[flush_i ? 1'b0 : fq_wp] <= fq_din;
  end

  assign parcel_valid_o      = fq_cnt != 2'd0;
  assign parcel_o            = fq[fq_rp].parcel;
  assign parcel_pc_o         = fq[fq_rp].pc;
  assign parcel_misaligned_o = fq[fq_rp].misaligned;
  assign parcel_err_o        = fq[fq_rp].err;

endmodule

// ==== logic/biu_ahb3lite.sv ====
// AHB-Lite master bus interface unit
// Core-side strobe/acknowledge handshake to single NONSEQ transfers
// Address phase register overlapping the data phase register
// HREADY and HRESP turned into acknowledge and error pulses

`timescale 1ns/1ps

module biu_ahb3lite
  import mem_subsys_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,

  // Core side
  input  logic     biu_stb_i,
  input  biu_req_t biu_req_i,
  output logic     biu_stb_ack_o,
  output logic     biu_ack_o,
  output logic     biu_err_o,
  output data_t    biu_q_o,

  // AHB-Lite side
  input  ahb_s2m_t ahb_i,
  output ahb_m2s_t ahb_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline state
  ////////////////////////////////////////////////////////////////////////////
  logic     aph_act;   // Transfer in address phase
  biu_req_t aph_req;   // Its address, control and pending write data
  logic     dph_act;   // Transfer in data phase
  data_t    dph_wdat;  // Write data for the data phase
  logic     bus_adv;   // Both phases move on this edge

  // Nothing moves while the slave inserts wait states
  assign bus_adv = ahb_i.hready;

  // A strobe is taken only when its address phase goes out at this edge
  assign biu_stb_ack_o = biu_stb_i & bus_adv;

  ////////////////////////////////////////////////////////////////////////////
  // Phase control
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aph_act <= 1'b0;
      dph_act <= 1'b0;
    end else if (bus_adv) begin
      aph_act <= biu_stb_i;  // No strobe gives IDLE
      dph_act <= aph_act;
    end
  end

  // Payload of both phases
  always_ff @(posedge clk_i) begin
    if (biu_stb_ack_o) begin
      aph_req <= biu_req_i;
    end
    if (bus_adv) begin
      dph_wdat <= aph_req.d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // AHB-Lite master outputs
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    ahb_o.haddr  = aph_req.adr;
    ahb_o.hwrite = aph_req.we;
    ahb_o.hsize  = aph_req.size;
    ahb_o.hprot  = aph_req.prot;
    ahb_o.hburst = HBURST_SINGLE;
    ahb_o.htrans = aph_act ? HTRANS_NONSEQ : HTRANS_IDLE;
    ahb_o.hwdata = dph_wdat;   // Lags the address by one phase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Core-side responses
  ////////////////////////////////////////////////////////////////////////////
  // Data phase ends on HREADY high; an ERROR response ends on its
  // second cycle, where HREADY is high with HRESP still set
  assign biu_ack_o = dph_act & ahb_i.hready & ~ahb_i.hresp;
  assign biu_err_o = dph_act & ahb_i.hready &  ahb_i.hresp;
  assign biu_q_o   = ahb_i.hrdata;

endmodule

// ==== logic/mem_subsys_pkg.sv ====
// Shared definitions for the hart memory subsystem
// Address and data widths, reset fetch address
// AHB-Lite transfer size, HTRANS, HBURST and HPROT codes
// Core-side bus request and AHB-Lite master/slave signal bundles

package mem_subsys_pkg;

  localparam int XLEN = 32;
  localparam int PLEN = 32;

  typedef logic [PLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] data_t;

  localparam addr_t PC_INIT = 32'h0000_0200;

  ////////////////////////////////////////////////////////////////////////////
  // AHB-Lite encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [2:0] biu_size_t;   // Same coding as HSIZE

  localparam biu_size_t SIZE_BYTE = 3'd0;
  localparam biu_size_t SIZE_HALF = 3'd1;
  localparam biu_size_t SIZE_WORD = 3'd2;

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [2:0] HBURST_SINGLE = 3'b000;

  // HPROT bit 0 is data/opcode, bit 1 privileged
  typedef logic [3:0] biu_prot_t;

  localparam biu_prot_t PROT_INSTR = 4'b0010;
  localparam biu_prot_t PROT_DATA  = 4'b0011;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    addr_t     adr;
    biu_size_t size;
    logic      we;
    biu_prot_t prot;
    data_t     d;      // Store data, lanes already placed
  } biu_req_t;

  typedef struct packed {
    addr_t      haddr;
    data_t      hwdata;
    logic       hwrite;
    logic [2:0] hsize;
    logic [2:0] hburst;
    logic [3:0] hprot;
    logic [1:0] htrans;
  } ahb_m2s_t;

  typedef struct packed {
    data_t hrdata;
    logic  hready;
    logic  hresp;    // High means ERROR
  } ahb_s2m_t;

endpackage
